// File: common/video_pkg.sv
// shared types and register numbers for the raster video generator
// imported by every module that needs a word, address, colour or counter type

package video_pkg;

    typedef logic [15:0] word_t;        // register and vram data word
    typedef logic [15:0] addr_t;        // vram word address
    typedef logic [7:0]  color_t;       // palette colour index
    typedef logic [10:0] hres_t;        // horizontal pixel counter
    typedef logic [9:0]  vres_t;        // vertical line counter

    // largest playfield count the register map can address (bit 3 of reg num)
    localparam int MAX_PF = 2;

    // scan states, horizontal walks them in this order
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,              // front porch
        SYNC      = 2'b01,              // sync pulse
        POST_SYNC = 2'b10,              // back porch
        VISIBLE   = 2'b11               // active pixels or lines
    } video_state_e;

    // config register numbers, playfield B adds 0x08 to the XR_PF_* entries
    typedef enum logic [4:0] {
        XR_VID_CTRL     = 5'h00,        // wr: interrupt pulse, rd: interrupt status
        XR_SCANLINE     = 5'h02,        // rd: vblank flag and current line
        XR_VID_HSIZE    = 5'h04,        // rd: visible width
        XR_VID_VSIZE    = 5'h05,        // rd: visible height
        XR_PF_GFX_CTRL  = 5'h10,        // colour base [15:8], blank [7]
        XR_PF_DISP_ADDR = 5'h12,        // first word of the frame
        XR_PF_LINE_LEN  = 5'h13         // words added per line
    } reg_num_e;

endpackage

// File: hdl/video_timing.sv
// horizontal and vertical sync engine, four scan states per axis
// registered sync and display-enable, combinational line and frame strobes
`timescale 1ns/1ns

module video_timing #(
    parameter int H_VISIBLE       = 640,
    parameter int H_FRONT_PORCH   = 16,
    parameter int H_SYNC_PULSE    = 96,
    parameter int H_BACK_PORCH    = 48,
    parameter int V_VISIBLE       = 480,
    parameter int V_FRONT_PORCH   = 10,
    parameter int V_SYNC_PULSE    = 2,
    parameter int V_BACK_PORCH    = 33,
    parameter bit H_SYNC_POLARITY = 1'b0,
    parameter bit V_SYNC_POLARITY = 1'b0
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    output logic            pixel_en_o,         // display enable for the next cycle
    output logic            h_line_end_o,       // last visible pixel of a line
    output logic            frame_start_o,      // last pixel before first visible line
    output logic            last_visible_o,     // last visible pixel of the frame
    output logic            v_blank_o,
    output video_pkg::vres_t v_count_o
);

    import video_pkg::*;

    // blank pixels come first on each line, blank lines come after the visible ones
    localparam int H_BLANK = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int V_FP_END = V_VISIBLE + V_FRONT_PORCH;
    localparam int V_SYNC_END = V_FP_END + V_SYNC_PULSE;

    video_state_e   h_state, h_state_next;
    video_state_e   v_state, v_state_next;
    hres_t          h_count, h_end;             // h_end is last count of h_state
    vres_t          v_count, v_end;

    always_comb begin
        case (h_state)
            PRE_SYNC:  h_end = hres_t'(H_FRONT_PORCH - 1);
            SYNC:      h_end = hres_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            POST_SYNC: h_end = hres_t'(H_BLANK - 1);
            default:   h_end = hres_t'(H_BLANK + H_VISIBLE - 1);
        endcase
        case (v_state)
            VISIBLE:   v_end = vres_t'(V_VISIBLE - 1);
            PRE_SYNC:  v_end = vres_t'(V_FP_END - 1);
            SYNC:      v_end = vres_t'(V_SYNC_END - 1);
            default:   v_end = vres_t'(V_SYNC_END + V_BACK_PORCH - 1);
        endcase
        h_state_next = (h_count == h_end) ? video_state_e'(h_state + 2'd1) : h_state;
        h_line_end_o = (h_state == VISIBLE) && (h_state_next == PRE_SYNC);
        // vertical only moves on at end of line
        v_state_next = (h_line_end_o && v_count == v_end) ? video_state_e'(v_state + 2'd1)
                                                          : v_state;
        frame_start_o  = h_line_end_o && (v_state == POST_SYNC) && (v_state_next == VISIBLE);
        last_visible_o = h_line_end_o && (v_state == VISIBLE) && (v_state_next == PRE_SYNC);
        pixel_en_o     = (h_state_next == VISIBLE) && (v_state_next == VISIBLE);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;
            v_state <= PRE_SYNC;
            h_count <= '0;
            v_count <= '0;
            hsync_o <= !H_SYNC_POLARITY;        // inactive level
            vsync_o <= !V_SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_line_end_o ? '0 : h_count + 1'b1;
            if (frame_start_o) begin
                v_count <= '0;                  // wrap to first visible line
            end else if (h_line_end_o) begin
                v_count <= v_count + 1'b1;
            end
            hsync_o <= (h_state_next == SYNC) ? H_SYNC_POLARITY : !H_SYNC_POLARITY;
            vsync_o <= (v_state_next == SYNC) ? V_SYNC_POLARITY : !V_SYNC_POLARITY;
            dv_de_o <= pixel_en_o;
        end
    end

    assign v_blank_o = (v_state != VISIBLE);    // scanline read bit 15
    assign v_count_o = v_count;

endmodule

// File: hdl/video_regs.sv
// config register file: write decode, registered read mux, interrupt pulses
// playfield registers repeat every 8 numbers, bit 3 picks the playfield
`timescale 1ns/1ns

module video_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480,
    parameter int NUM_PF    = 2
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,
    input  video_pkg::reg_num_e     reg_num_i,
    input  video_pkg::word_t        reg_data_i,
    input  wire logic [3:0]         intr_status_i,
    input  video_pkg::vres_t        v_count_i,
    input  wire logic               v_blank_i,
    input  wire logic               last_visible_i,
    output video_pkg::word_t        reg_data_o,
    output logic [3:0]              intr_signal_o,      // one-cycle pulses
    output logic                    pf_blank_o      [NUM_PF],
    output video_pkg::color_t       pf_colorbase_o  [NUM_PF],
    output video_pkg::addr_t        pf_start_addr_o [NUM_PF],
    output video_pkg::word_t        pf_line_len_o   [NUM_PF]
);

    import video_pkg::*;

    logic [$clog2(MAX_PF)-1:0] pf_sel;  // playfield picked by reg num bit 3
    reg_num_e   pf_reg;                 // reg num folded onto playfield A
    word_t      rd_pf;
    word_t      rd_data;

    assign pf_sel = reg_num_i[3];
    assign pf_reg = reg_num_e'({reg_num_i[4], 1'b0, reg_num_i[2:0]});

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o <= 4'b0;
            for (int p = 0; p < NUM_PF; p++) begin
                pf_blank_o[p]      <= 1'b1;                 // start blanked
                pf_colorbase_o[p]  <= '0;
                pf_start_addr_o[p] <= '0;
                pf_line_len_o[p]   <= word_t'(H_VISIBLE / 2);   // two pixels per word
            end
        end else begin
            intr_signal_o <= 4'b0;
            if (reg_wr_i && reg_num_i == XR_VID_CTRL) begin
                intr_signal_o <= reg_data_i[3:0];
            end
            if (last_visible_i) begin
                intr_signal_o[3] <= 1'b1;                   // vsync interrupt
            end
            for (int p = 0; p < NUM_PF; p++) begin
                if (reg_wr_i && reg_num_i[4] && pf_sel == p) begin
                    case (pf_reg)
                        XR_PF_GFX_CTRL: begin
                            pf_colorbase_o[p] <= reg_data_i[15:8];
                            pf_blank_o[p]     <= reg_data_i[7];
                        end
                        XR_PF_DISP_ADDR: pf_start_addr_o[p] <= reg_data_i;
                        XR_PF_LINE_LEN:  pf_line_len_o[p]   <= reg_data_i;
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        rd_pf = '0;                         // absent playfields read 0
        for (int p = 0; p < NUM_PF; p++) begin
            if (pf_sel == p) begin
                case (pf_reg)
                    XR_PF_GFX_CTRL:  rd_pf = {pf_colorbase_o[p], pf_blank_o[p], 7'b0};
                    XR_PF_DISP_ADDR: rd_pf = pf_start_addr_o[p];
                    XR_PF_LINE_LEN:  rd_pf = pf_line_len_o[p];
                    default:         rd_pf = '0;
                endcase
            end
        end
        case (reg_num_i)
            XR_VID_CTRL:  rd_data = {12'h000, intr_status_i};
            XR_SCANLINE:  rd_data = {v_blank_i, 15'(v_count_i)};
            XR_VID_HSIZE: rd_data = word_t'(H_VISIBLE);
            XR_VID_VSIZE: rd_data = word_t'(V_VISIBLE);
            default:      rd_data = reg_num_i[4] ? rd_pf : '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;
    end

endmodule

// File: playfield/video_playfield.sv
// one 8 bpp bitmap playfield: line address, two-word fetch buffer, pixel shift-out
// each vram word gives two colour indices, high byte first
`timescale 1ns/1ns

module video_playfield (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           pixel_en_i,         // a pixel is displayed next cycle
    input  wire logic           h_line_end_i,
    input  wire logic           frame_start_i,
    input  wire logic           pf_blank_i,
    input  video_pkg::color_t   pf_colorbase_i,
    input  video_pkg::addr_t    pf_start_addr_i,
    input  video_pkg::word_t    pf_line_len_i,
    input  wire logic           fetch_grant_i,
    input  video_pkg::word_t    vram_data_i,        // shared by all playfields
    output logic                fetch_req_o,
    output video_pkg::addr_t    fetch_addr_o,
    output video_pkg::color_t   color_index_o
);

    import video_pkg::*;

    addr_t      line_base;          // first word of the current line
    logic       armed;              // first frame_start seen since reset
    logic       rd_pend;            // granted last cycle, data on vram_data_i now
    word_t      buf_q [2];
    logic [1:0] buf_cnt;            // words held in buf_q
    logic       half;               // low byte of the word is next
    color_t     lo_byte;
    word_t      head;
    logic       restart;
    logic       pop;

    always_comb begin
        restart = h_line_end_i || frame_start_i;
        pop     = pixel_en_i && !half;                  // word taken on its high byte
        head    = (buf_cnt == 2'd0) ? vram_data_i : buf_q[0];   // bypass when empty
        // room counts the word still in flight
        fetch_req_o = armed && (buf_cnt + {1'b0, rd_pend} < 2'd2);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            armed         <= 1'b0;
            rd_pend       <= 1'b0;
            buf_cnt       <= 2'd0;
            half          <= 1'b0;
            line_base     <= '0;
            fetch_addr_o  <= '0;
            color_index_o <= '0;
        end else begin
            rd_pend <= fetch_req_o && fetch_grant_i && !restart;   // old line data dropped
            if (frame_start_i) begin
                armed        <= 1'b1;
                line_base    <= pf_start_addr_i;
                fetch_addr_o <= pf_start_addr_i;
            end else if (h_line_end_i) begin
                line_base    <= line_base + pf_line_len_i;
                fetch_addr_o <= line_base + pf_line_len_i;
            end else if (fetch_req_o && fetch_grant_i) begin
                fetch_addr_o <= fetch_addr_o + 1'b1;
            end
            if (restart) begin
                buf_cnt <= 2'd0;                        // flush for the next line
                half    <= 1'b0;
            end else begin
                buf_cnt <= buf_cnt + {1'b0, rd_pend} - {1'b0, pop};
                if (pixel_en_i) half <= !half;
            end
            if (!pixel_en_i || pf_blank_i) begin
                color_index_o <= '0;
            end else begin
                color_index_o <= (half ? lo_byte : head[15:8]) ^ pf_colorbase_i;
            end
        end
    end

    // buffer words and the saved low byte
    always_ff @(posedge clk) begin
        if (pop) begin
            lo_byte  <= head[7:0];
            buf_q[0] <= (buf_cnt == 2'd2) ? buf_q[1] : vram_data_i;
            buf_q[1] <= vram_data_i;
        end else if (rd_pend) begin
            buf_q[buf_cnt[0]] <= vram_data_i;           // append behind held word
        end
    end

endmodule

// File: hdl/vram_arbiter.sv
// fixed-priority vram arbiter, lowest-numbered requesting playfield wins
// purely combinational, a loser keeps its request up and retries
`timescale 1ns/1ns

module vram_arbiter #(
    parameter int NUM_PF = 2
) (
    input  wire logic           fetch_req_i  [NUM_PF],
    input  video_pkg::addr_t    fetch_addr_i [NUM_PF],
    output logic                fetch_grant_o [NUM_PF],     // one-hot
    output logic                vram_sel_o,
    output video_pkg::addr_t    vram_addr_o
);

    logic taken;                    // a lower playfield already holds the port

    always_comb begin
        taken       = 1'b0;
        vram_addr_o = fetch_addr_i[0];  // playfield 0 address when idle
        for (int p = 0; p < NUM_PF; p++) begin
            fetch_grant_o[p] = fetch_req_i[p] && !taken;
            if (fetch_grant_o[p]) begin
                vram_addr_o = fetch_addr_i[p];
            end
            taken = taken || fetch_req_i[p];
        end
        vram_sel_o = taken;         // any request pending
    end

endmodule

// File: hdl/video_gen.sv
// raster video generator top: sync engine, config registers, playfields, vram arbiter
// drive timing through the parameters, NUM_PF selects one or two playfields
`timescale 1ns/1ns

module video_gen #(
    parameter int H_VISIBLE       = 640,
    parameter int H_FRONT_PORCH   = 16,
    parameter int H_SYNC_PULSE    = 96,
    parameter int H_BACK_PORCH    = 48,
    parameter int V_VISIBLE       = 480,
    parameter int V_FRONT_PORCH   = 10,
    parameter int V_SYNC_PULSE    = 2,
    parameter int V_BACK_PORCH    = 33,
    parameter bit H_SYNC_POLARITY = 1'b0,
    parameter bit V_SYNC_POLARITY = 1'b0,
    parameter int NUM_PF          = 2      // 1 or 2 playfields
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,       // config register write strobe
    input  video_pkg::reg_num_e     reg_num_i,
    input  video_pkg::word_t        reg_data_i,
    output video_pkg::word_t        reg_data_o,     // read data, one cycle after reg_num_i
    input  wire logic [3:0]         intr_status_i,
    output logic [3:0]              intr_signal_o,
    output logic                    vram_sel_o,
    output video_pkg::addr_t        vram_addr_o,
    input  video_pkg::word_t        vram_data_i,    // data one cycle after a select
    output video_pkg::color_t       color_index_o [NUM_PF],
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);

    import video_pkg::*;

    logic   pixel_en;                   // next cycle is a displayed pixel
    logic   h_line_end;
    logic   frame_start;
    logic   last_visible;
    logic   v_blank;
    vres_t  v_count;

    logic   pf_blank      [NUM_PF];
    color_t pf_colorbase  [NUM_PF];
    addr_t  pf_start_addr [NUM_PF];
    word_t  pf_line_len   [NUM_PF];
    logic   fetch_req     [NUM_PF];
    logic   fetch_grant   [NUM_PF];     // one-hot
    addr_t  fetch_addr    [NUM_PF];

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT_PORCH(H_FRONT_PORCH),
        .H_SYNC_PULSE(H_SYNC_PULSE), .H_BACK_PORCH(H_BACK_PORCH),
        .V_VISIBLE(V_VISIBLE), .V_FRONT_PORCH(V_FRONT_PORCH),
        .V_SYNC_PULSE(V_SYNC_PULSE), .V_BACK_PORCH(V_BACK_PORCH),
        .H_SYNC_POLARITY(H_SYNC_POLARITY), .V_SYNC_POLARITY(V_SYNC_POLARITY)
    ) u_timing (
        .clk(clk), .reset_i(reset_i),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .pixel_en_o(pixel_en), .h_line_end_o(h_line_end), .frame_start_o(frame_start),
        .last_visible_o(last_visible), .v_blank_o(v_blank), .v_count_o(v_count)
    );

    video_regs #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE), .NUM_PF(NUM_PF)) u_regs (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .intr_status_i(intr_status_i), .v_count_i(v_count), .v_blank_i(v_blank),
        .last_visible_i(last_visible), .reg_data_o(reg_data_o),
        .intr_signal_o(intr_signal_o), .pf_blank_o(pf_blank),
        .pf_colorbase_o(pf_colorbase), .pf_start_addr_o(pf_start_addr),
        .pf_line_len_o(pf_line_len)
    );

    for (genvar p = 0; p < NUM_PF; p++) begin : g_pf
        video_playfield u_pf (
            .clk(clk), .reset_i(reset_i),
            .pixel_en_i(pixel_en), .h_line_end_i(h_line_end), .frame_start_i(frame_start),
            .pf_blank_i(pf_blank[p]), .pf_colorbase_i(pf_colorbase[p]),
            .pf_start_addr_i(pf_start_addr[p]), .pf_line_len_i(pf_line_len[p]),
            .fetch_grant_i(fetch_grant[p]), .vram_data_i(vram_data_i),   // shared data bus
            .fetch_req_o(fetch_req[p]), .fetch_addr_o(fetch_addr[p]),
            .color_index_o(color_index_o[p])
        );
    end

    vram_arbiter #(.NUM_PF(NUM_PF)) u_arbiter (
        .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
        .fetch_grant_o(fetch_grant), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o)
    );

endmodule

// File: verif/tb_checks.svh
// compare tasks, error counter and closing summary for the video generator testbench
// included inside the testbench module after the video_pkg import
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_cnt   = 0;              // failed checks
int check_cnt = 0;              // every check made

task automatic check_word(input string name, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_color(input string name, input color_t got, input color_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("ERR %0t ns %s got %b expected %b", $time, name, got, exp);
    end
endtask

// failures that are not a single wrong value
task automatic flag_failure(input string what);
    check_cnt++;
    err_cnt++;
    $display("at %0t ns: %s", $time, what);
endtask

task automatic print_summary();
    $display("checks made %0d, errors found %0d", check_cnt, err_cnt);
endtask

`endif

// File: verif/tb_video_gen.sv
// directed testbench for the raster video generator with two playfields
// run by sim.sh with a vram model that answers address xor a55a one cycle after a select
`timescale 1ns/1ns

module tb_video_gen;

    import video_pkg::*;

    localparam int    H_VIS          = 16;
    localparam int    H_TOTAL        = 22;                  // 16 visible + 6 blank
    localparam int    V_VIS          = 4;
    localparam int    FRAME_CYCLES   = 154;                 // 7 lines of 22 pixels
    localparam int    TIMEOUT_CYCLES = 10 * FRAME_CYCLES + 200;  // ten frames + reg traffic
    localparam bit    H_POL          = 1'b0;                // active low syncs
    localparam bit    V_POL          = 1'b0;
    localparam word_t RAM_KEY        = 16'hA55A;

    logic       clk;
    logic       reset;
    logic       reg_wr;
    reg_num_e   reg_num;
    word_t      reg_wdata;
    word_t      reg_rdata;
    logic [3:0] intr_status;
    logic [3:0] intr_signal;
    logic       vram_sel;
    addr_t      vram_addr;
    word_t      vram_data;
    word_t      vram_next;                                  // answer for the next cycle
    color_t     color_index [2];
    logic       hsync;
    logic       vsync;
    logic       dv_de;
    int         cycle_cnt;

    // playfield setup as last written by the tests
    addr_t      pf_start [2];
    word_t      pf_len   [2];
    color_t     pf_cb    [2];
    logic       pf_blank [2];

    `include "tb_checks.svh"

    video_gen #(
        .H_VISIBLE(H_VIS), .H_FRONT_PORCH(2), .H_SYNC_PULSE(2), .H_BACK_PORCH(2),
        .V_VISIBLE(V_VIS), .V_FRONT_PORCH(1), .V_SYNC_PULSE(1), .V_BACK_PORCH(1),
        .H_SYNC_POLARITY(H_POL), .V_SYNC_POLARITY(V_POL), .NUM_PF(2)
    ) u_dut (
        .clk(clk), .reset_i(reset), .reg_wr_i(reg_wr), .reg_num_i(reg_num),
        .reg_data_i(reg_wdata), .reg_data_o(reg_rdata), .intr_status_i(intr_status),
        .intr_signal_o(intr_signal), .vram_sel_o(vram_sel), .vram_addr_o(vram_addr),
        .vram_data_i(vram_data), .color_index_o(color_index),
        .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                                   // 8 ns period

    // vram model returns the word selected one cycle earlier
    always @(negedge clk) begin
        vram_data <= vram_next;
        if (vram_sel) vram_next <= vram_addr ^ RAM_KEY;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic reg_num_e pf_reg_num(input int p, input reg_num_e base);
        return reg_num_e'(base + 5'(p * 8));                // bit 3 picks playfield B
    endfunction

    // expected index for pixel x of visible line v with the high byte of each word first
    function automatic color_t pixel_color(input int p, input int v, input int x);
        word_t word;
        if (pf_blank[p]) return '0;
        word = (pf_start[p] + word_t'(v) * pf_len[p] + word_t'(x / 2)) ^ RAM_KEY;
        return ((x % 2 == 0) ? word[15:8] : word[7:0]) ^ pf_cb[p];
    endfunction

    task automatic write_reg(input reg_num_e num, input word_t data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_num   = num;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic read_expect(input reg_num_e num, input word_t exp, input string name);
        @(negedge clk);
        reg_num = num;
        @(negedge clk);                                     // registered read data
        check_word(name, reg_rdata, exp);
    endtask

    task automatic wait_vsync_end();
        while (vsync != V_POL) @(negedge clk);
        while (vsync == V_POL) @(negedge clk);              // back porch line starts here
    endtask

    task automatic verify_reset_state();
        check_bit("dv_de_o", dv_de, 1'b0);
        check_bit("hsync_o", hsync, !H_POL);
        check_bit("vsync_o", vsync, !V_POL);
        check_bit("vram_sel_o", vram_sel, 1'b0);
        check_word("intr_signal_o", {12'h000, intr_signal}, 16'h0000);
        for (int p = 0; p < 2; p++) begin
            check_color($sformatf("color_index_o[%0d]", p), color_index[p], 8'h00);
            read_expect(pf_reg_num(p, XR_PF_GFX_CTRL), 16'h0080, "pf gfx ctrl after reset");
            read_expect(pf_reg_num(p, XR_PF_DISP_ADDR), 16'h0000, "pf disp addr after reset");
            read_expect(pf_reg_num(p, XR_PF_LINE_LEN), 16'd8, "pf line len after reset");
        end
    endtask

    task automatic register_readback();
        word_t gfx;
        word_t addr;
        word_t len;
        for (int p = 0; p < 2; p++) begin
            gfx  = word_t'($urandom);
            addr = word_t'($urandom);
            len  = word_t'($urandom);
            write_reg(pf_reg_num(p, XR_PF_GFX_CTRL), gfx);
            write_reg(pf_reg_num(p, XR_PF_DISP_ADDR), addr);
            write_reg(pf_reg_num(p, XR_PF_LINE_LEN), len);
            read_expect(pf_reg_num(p, XR_PF_GFX_CTRL), gfx & 16'hFF80, "pf gfx ctrl");
            read_expect(pf_reg_num(p, XR_PF_DISP_ADDR), addr, "pf disp addr");
            read_expect(pf_reg_num(p, XR_PF_LINE_LEN), len, "pf line len");
        end
        read_expect(XR_VID_HSIZE, word_t'(H_VIS), "vid hsize");
        read_expect(XR_VID_VSIZE, word_t'(V_VIS), "vid vsize");
        intr_status = 4'($urandom);
        read_expect(XR_VID_CTRL, {12'h000, intr_status}, "vid ctrl status");
    endtask

    task automatic sync_timing();
        int   width;
        int   period;
        int   run;
        int   lines;
        int   de_cycles;
        int   vblank_cnt;
        logic prev_de;
        reg_num = XR_SCANLINE;                              // held for the whole test
        while (hsync == H_POL) @(negedge clk);
        while (hsync != H_POL) @(negedge clk);              // aligned to an hsync start
        width = 0;
        while (hsync == H_POL) begin
            width++;
            @(negedge clk);
        end
        period = width;
        while (hsync != H_POL) begin
            period++;
            @(negedge clk);
        end
        check_word("hsync_o active width", word_t'(width), 16'd2);
        check_word("hsync_o period", word_t'(period), word_t'(H_TOTAL));
        while (vsync != V_POL) @(negedge clk);
        width = 0;
        while (vsync == V_POL) begin
            width++;
            @(negedge clk);
        end
        check_word("vsync_o active width", word_t'(width), word_t'(H_TOTAL));
        run = 0;
        lines = 0;
        de_cycles = 0;
        vblank_cnt = 0;
        prev_de = 1'b0;
        repeat (FRAME_CYCLES) begin                         // one whole frame from back porch
            if (dv_de) begin
                run++;
                de_cycles++;
                if (reg_rdata[15]) flag_failure("scanline read shows vblank on a visible pixel");
            end else if (prev_de) begin
                check_word("dv_de_o high cycles per line", word_t'(run), word_t'(H_VIS));
                run = 0;
                lines++;
            end
            if (reg_rdata[15]) vblank_cnt++;
            prev_de = dv_de;
            @(negedge clk);
        end
        check_word("visible lines per frame", word_t'(lines), word_t'(V_VIS));
        check_word("dv_de_o cycles per frame", word_t'(de_cycles), word_t'(H_VIS * V_VIS));
        check_word("scanline vblank cycles", word_t'(vblank_cnt), word_t'(3 * H_TOTAL));
    endtask

    // checks both playfields over the four visible lines of the next frame
    task automatic compare_frame_pixels();
        int   line;
        int   x;
        logic prev_de;
        line = 0;
        x = 0;
        prev_de = 1'b0;
        wait_vsync_end();
        while (line < V_VIS) begin
            if (dv_de) begin
                for (int p = 0; p < 2; p++) begin
                    check_color($sformatf("color_index_o[%0d]", p), color_index[p],
                                pixel_color(p, line, x));
                end
                x++;
            end else if (prev_de) begin
                line++;
                x = 0;
            end
            prev_de = dv_de;
            @(negedge clk);
        end
    endtask

    task automatic pixel_data();
        for (int p = 0; p < 2; p++) begin
            pf_start[p] = addr_t'($urandom);
            pf_len[p]   = word_t'($urandom);
            pf_cb[p]    = color_t'($urandom);
            pf_blank[p] = 1'b0;
            write_reg(pf_reg_num(p, XR_PF_GFX_CTRL), {pf_cb[p], 1'b0, 7'b0});
            write_reg(pf_reg_num(p, XR_PF_DISP_ADDR), pf_start[p]);
            write_reg(pf_reg_num(p, XR_PF_LINE_LEN), pf_len[p]);
        end
        compare_frame_pixels();                             // both fetching at once
        pf_blank[1] = 1'b1;
        write_reg(pf_reg_num(1, XR_PF_GFX_CTRL), {pf_cb[1], 1'b1, 7'b0});
        compare_frame_pixels();                             // B blanked while A stays live
    endtask

    task automatic interrupt_pulses();
        int   pulses;
        int   lines;
        logic prev_de;
        wait_vsync_end();                                   // far from the last visible line
        write_reg(XR_VID_CTRL, 16'h0005);
        check_word("intr_signal_o after vid ctrl write", {12'h000, intr_signal}, 16'h0005);
        @(negedge clk);
        check_word("intr_signal_o one cycle later", {12'h000, intr_signal}, 16'h0000);
        pulses = 0;
        lines = 0;
        prev_de = 1'b0;
        repeat (FRAME_CYCLES) begin
            if (prev_de && !dv_de) lines++;
            if (intr_signal[3]) begin
                pulses++;
                check_word("intr_signal_o vsync pulse", {12'h000, intr_signal}, 16'h0008);
                if (!(prev_de && !dv_de) || lines != V_VIS) begin
                    flag_failure("vsync interrupt did not follow the last visible pixel");
                end
            end
            prev_de = dv_de;
            @(negedge clk);
        end
        check_word("vsync interrupt pulses per frame", word_t'(pulses), 16'd1);
    endtask

    initial begin
        void'($urandom(32'h313a_d20a));                     // single seed for the run
        reset       = 1'b1;
        reg_wr      = 1'b0;
        reg_num     = XR_VID_CTRL;
        reg_wdata   = '0;
        intr_status = '0;
        vram_data   <= '0;
        vram_next   <= '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        verify_reset_state();                               // before the engine moves on
        register_readback();
        sync_timing();
        pixel_data();
        interrupt_pulses();
        print_summary();
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+verif
common/video_pkg.sv
hdl/video_timing.sv
hdl/video_regs.sv
playfield/video_playfield.sv
hdl/vram_arbiter.sv
hdl/video_gen.sv
verif/tb_video_gen.sv

// File: sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, then searches the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_video_gen -f build.f -o tb_video_gen \
    && ./obj_dir/tb_video_gen > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log \
    && { echo "simulation reported a failure"; exit 1; } \
    || { echo "no failure found in sim.log"; exit 0; }
